// ==== design/alu.sv ====
module alu
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  alu_op_e alu_op,
    input  word_t   src1,
    input  word_t   src2,
    input  logic    div_start,
    output word_t   result,
    output word_t   hi_result,
    output logic    overflow,
    output logic    div_done
);

    word_t      sum;
    word_t      diff;
    word_t      quotient;
    word_t      remainder;
    logic [4:0] shamt;
    logic       is_signed_div;

    assign sum           = src1 + src2;
    assign diff          = src1 - src2;
    assign shamt         = src1[4:0];  // sa or rs for the variable forms
    assign is_signed_div = (alu_op == alu_div);

    div_unit u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (is_signed_div),
        .dividend  (src1),
        .divisor   (src2),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    always_comb begin
        case (alu_op)
            alu_add,
            alu_addu: result = sum;
            alu_sub,
            alu_subu: result = diff;
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_nor:  result = ~(src1 | src2);
            alu_slt:  result = {31'd0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'd0, src1 < src2};
            alu_sll:  result = src2 << shamt;
            alu_srl:  result = src2 >> shamt;
            alu_sra:  result = word_t'($signed(src2) >>> shamt);
            alu_lui:  result = {src2[15:0], 16'd0};
            alu_div,
            alu_divu: result = quotient;
            default:  result = sum;
        endcase
    end

    assign hi_result = remainder;

    // signed overflow, add and sub only
    always_comb begin
        case (alu_op)
            alu_add: overflow = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            alu_sub: overflow = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== design/bus_pkg.sv ====
package bus_pkg;

    localparam int RAM_DEPTH = 256;
    localparam int RAM_AW    = 8;

    typedef logic [29:0] wb_adr_t;  // word address, byte address [31:2]
    typedef logic [3:0]  wb_sel_t;

    typedef struct packed {
        logic          cyc;
        logic          stb;
        logic          we;
        wb_adr_t       adr;
        wb_sel_t       sel;
        cpu_pkg::word_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic           ack;
        cpu_pkg::word_t dat_r;
    } wb_rsp_t;

endpackage

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // one-cycle ops plus the two divides
    typedef enum logic [3:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_div,
        alu_divu
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lw,
        mem_lh,
        mem_lhu,
        mem_lb,
        mem_lbu,
        mem_sb,
        mem_sh,
        mem_sw,
        mem_swl,
        mem_swr
    } mem_op_e;

    typedef enum logic [1:0] {
        src1_rs,
        src1_sa,   // shift amount from imm[10:6]
        src1_pc
    } src1_sel_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_imm_zero,
        src2_imm_sign,
        src2_eight    // link address pc + 8
    } src2_sel_e;

    // cp0 cause codes, syscall/bp/ri only come in from decode
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,
        exc_ov   = 5'd12
    } exc_code_e;

    typedef struct packed {
        word_t     pc;
        word_t     rs_value;
        word_t     rt_value;
        logic [15:0] imm;
        alu_op_e   alu_op;
        mem_op_e   mem_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        logic      gr_we;
        reg_addr_t dest;
        logic      in_ex;
        exc_code_e in_exc_code;
    } ds_to_es_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     hi_result;  // divide remainder
        reg_addr_t dest;
        logic      gr_we;
        mem_op_e   mem_op;
        word_t     load_word;  // raw word, extension is done later
        logic      ex;
        exc_code_e exc_code;
    } es_to_ms_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     result;
        logic      is_load;
    } es_fwd_t;

endpackage

// ==== design/data_ram.sv ====
module data_ram
    import cpu_pkg::*;
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    word_t             mem [RAM_DEPTH];
    logic [RAM_AW-1:0] idx;
    logic              ack_r;
    word_t             rdata_r;

    assign idx = wb_req.adr[RAM_AW-1:0];   // upper address bits ignored

    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) mem[i] = '0;
    end

    // one wait state, ack for a single cycle
    always_ff @(posedge clk) begin
        if (reset) ack_r <= 1'b0;
        else       ack_r <= wb_req.cyc && wb_req.stb && !ack_r;
    end

    always_ff @(posedge clk) begin
        if (wb_req.stb && !ack_r) rdata_r <= mem[idx];
        if (ack_r && wb_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req.sel[b]) mem[idx][8*b +: 8] <= wb_req.dat_w[8*b +: 8];
            end
        end
    end

    assign wb_rsp.ack   = ack_r;
    assign wb_rsp.dat_r = rdata_r;

endmodule

// ==== design/div_unit.sv ====
module div_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  is_signed,
    input  word_t dividend,
    input  word_t divisor,
    output word_t quotient,
    output word_t remainder,
    output logic  done
);

    word_t       quo_r;     // dividend magnitude shifts out, quotient bits shift in
    word_t       rem_r;
    word_t       dvs_r;
    logic [4:0]  count;
    logic        busy;
    logic        neg_q;
    logic        neg_r;
    logic [32:0] shifted;
    logic [32:0] trial;

    assign shifted = {rem_r, quo_r[31]};
    assign trial   = shifted - {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            count <= count + 5'd1;
            if (count == 5'd31) begin
                busy <= 1'b0;
                done <= 1'b1;   // held until the next start
            end
        end
    end

    // datapath, no reset needed
    always_ff @(posedge clk) begin
        if (start) begin
            quo_r <= (is_signed && dividend[31]) ? -dividend : dividend;
            dvs_r <= (is_signed && divisor[31]) ? -divisor : divisor;
            rem_r <= '0;
            neg_q <= is_signed && (dividend[31] ^ divisor[31]);
            neg_r <= is_signed && dividend[31];
        end else if (busy) begin
            if (!trial[32]) begin
                rem_r <= trial[31:0];
                quo_r <= {quo_r[30:0], 1'b1};
            end else begin
                rem_r <= shifted[31:0];
                quo_r <= {quo_r[30:0], 1'b0};
            end
        end
    end

    // sign fix-up, truncation toward zero
    assign quotient  = neg_q ? -quo_r : quo_r;
    assign remainder = neg_r ? -rem_r : rem_r;

endmodule

// ==== design/exe_stage.sv ====
module exe_stage
    import cpu_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_valid,
    input  ds_to_es_t ds_bus,
    output logic      es_allowin,
    output logic      es_valid,
    output es_to_ms_t es_bus,
    input  logic      ms_allowin,
    output es_fwd_t   es_fwd,
    input  logic      flush,
    input  logic      later_ex,
    output wb_req_t   wb_req,
    input  wb_rsp_t   wb_rsp
);

    ds_to_es_t  inst_r;
    logic       valid_r;
    logic       capture;
    logic       ready_go;
    word_t      src1;
    word_t      src2;
    word_t      alu_result;
    word_t      alu_hi;
    logic       overflow;
    logic       div_start;
    logic       div_done;
    logic       div_issued;     // one start per divide
    wb_sel_t    store_sel;
    word_t      store_wdata;
    logic       ades;
    logic       adel;
    logic       is_div;
    logic       is_load;
    logic       is_store;
    logic       ex;
    logic       skip;
    exc_code_e  exc_code;
    logic       mem_busy;       // bus cycle waiting for ack
    logic       mem_done;       // access finished, not repeated under back-pressure
    logic       bus_hold;
    word_t      load_word_r;

    assign is_div   = inst_r.alu_op inside {alu_div, alu_divu};
    assign is_load  = inst_r.mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
    assign is_store = inst_r.mem_op inside {mem_sb, mem_sh, mem_sw, mem_swl, mem_swr};

    always_comb begin
        case (inst_r.src1_sel)
            src1_sa: src1 = {27'd0, inst_r.imm[10:6]};
            src1_pc: src1 = inst_r.pc;
            default: src1 = inst_r.rs_value;
        endcase
        case (inst_r.src2_sel)
            src2_imm_zero: src2 = {16'd0, inst_r.imm};
            src2_imm_sign: src2 = {{16{inst_r.imm[15]}}, inst_r.imm};
            src2_eight:    src2 = 32'd8;
            default:       src2 = inst_r.rt_value;
        endcase
    end

    alu u_alu (
        .clk       (clk),
        .reset     (reset),
        .alu_op    (inst_r.alu_op),
        .src1      (src1),
        .src2      (src2),
        .div_start (div_start),
        .result    (alu_result),
        .hi_result (alu_hi),
        .overflow  (overflow),
        .div_done  (div_done)
    );

    store_align u_align (
        .mem_op         (inst_r.mem_op),
        .addr           (alu_result),
        .rt_value       (inst_r.rt_value),
        .sel            (store_sel),
        .wdata          (store_wdata),
        .addr_err_store (ades),
        .addr_err_load  (adel)
    );

    // priority: incoming, ov, ades, adel
    assign ex = inst_r.in_ex || overflow || ades || adel;
    always_comb begin
        if (inst_r.in_ex)  exc_code = inst_r.in_exc_code;
        else if (overflow) exc_code = exc_ov;
        else if (ades)     exc_code = exc_ades;
        else if (adel)     exc_code = exc_adel;
        else               exc_code = exc_none;
    end

    assign skip      = ex || later_ex;  // no divide, no bus cycle
    assign div_start = valid_r && is_div && !div_issued && !skip;
    assign bus_hold  = mem_busy && !wb_rsp.ack;

    always_comb begin
        if (bus_hold)
            ready_go = 1'b0;
        else if (skip)
            ready_go = 1'b1;
        else if (is_div)
            ready_go = div_issued && div_done;
        else if (is_load || is_store)
            ready_go = mem_done || wb_rsp.ack;
        else
            ready_go = 1'b1;
    end

    assign es_allowin = !bus_hold && (!valid_r || (ready_go && ms_allowin));
    assign es_valid   = valid_r && ready_go;
    assign capture    = ds_valid && es_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (flush) begin
            valid_r <= 1'b0;    // a pending bus cycle still runs to ack
        end else if (es_allowin) begin
            valid_r <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) inst_r <= ds_bus;
        if (wb_rsp.ack) load_word_r <= wb_rsp.dat_r;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            div_issued <= 1'b0;
            mem_done   <= 1'b0;
            mem_busy   <= 1'b0;
        end else begin
            if (capture) div_issued <= 1'b0;
            else if (div_start) div_issued <= 1'b1;

            if (capture) mem_done <= 1'b0;
            else if (wb_rsp.ack && valid_r) mem_done <= 1'b1;

            if (wb_rsp.ack) mem_busy <= 1'b0;
            else if (wb_req.cyc) mem_busy <= 1'b1;
        end
    end

    // wishbone master, address and data come straight from the held item
    always_comb begin
        wb_req.cyc   = mem_busy || (valid_r && (is_load || is_store) && !mem_done && !skip);
        wb_req.stb   = wb_req.cyc;
        wb_req.we    = is_store;
        wb_req.adr   = alu_result[31:2];
        wb_req.sel   = is_store ? store_sel : 4'b1111;  // loads read the whole word
        wb_req.dat_w = store_wdata;
    end

    always_comb begin
        es_bus.pc        = inst_r.pc;
        es_bus.result    = alu_result;
        es_bus.hi_result = alu_hi;
        es_bus.dest      = inst_r.dest;
        es_bus.gr_we     = inst_r.gr_we;
        es_bus.mem_op    = inst_r.mem_op;
        es_bus.load_word = wb_rsp.ack ? wb_rsp.dat_r : load_word_r;
        es_bus.ex        = ex;
        es_bus.exc_code  = exc_code;
    end

    always_comb begin
        es_fwd.valid   = valid_r && inst_r.gr_we;
        es_fwd.dest    = inst_r.dest;
        es_fwd.result  = alu_result;
        es_fwd.is_load = is_load;
    end

endmodule

// ==== design/exe_top.sv ====
module exe_top
    import cpu_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_valid,
    input  ds_to_es_t ds_bus,
    output logic      es_allowin,
    output logic      es_valid,
    output es_to_ms_t es_bus,
    input  logic      ms_allowin,
    output es_fwd_t   es_fwd,
    input  logic      flush,
    input  logic      later_ex
);

    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    exe_stage u_exe (
        .clk        (clk),
        .reset      (reset),
        .ds_valid   (ds_valid),
        .ds_bus     (ds_bus),
        .es_allowin (es_allowin),
        .es_valid   (es_valid),
        .es_bus     (es_bus),
        .ms_allowin (ms_allowin),
        .es_fwd     (es_fwd),
        .flush      (flush),
        .later_ex   (later_ex),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

    data_ram u_ram (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

// ==== design/store_align.sv ====
module store_align
    import cpu_pkg::*;
(
    input  mem_op_e    mem_op,
    input  word_t      addr,
    input  word_t      rt_value,
    output logic [3:0] sel,
    output word_t      wdata,
    output logic       addr_err_store,
    output logic       addr_err_load
);

    logic [1:0] ofs;

    assign ofs = addr[1:0];

    always_comb begin
        sel   = 4'b0000;    // loads and non-memory ops
        wdata = rt_value;
        case (mem_op)
            mem_sb: begin
                sel   = 4'b0001 << ofs;
                wdata = {4{rt_value[7:0]}};
            end
            mem_sh: begin
                sel   = ofs[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            mem_sw: sel = 4'b1111;
            mem_swl: begin
                // top bytes of rt go into lanes 0..ofs
                sel   = 4'b1111 >> (2'd3 - ofs);
                wdata = rt_value >> {2'd3 - ofs, 3'b000};
            end
            mem_swr: begin
                // low bytes of rt go into lanes ofs..3
                sel   = 4'b1111 << ofs;
                wdata = rt_value << {ofs, 3'b000};
            end
            default: ;
        endcase
    end

    assign addr_err_store = (mem_op == mem_sh && ofs[0]) || (mem_op == mem_sw && ofs != 2'd0);
    assign addr_err_load  = ((mem_op == mem_lh || mem_op == mem_lhu) && ofs[0])
                          || (mem_op == mem_lw && ofs != 2'd0);

endmodule

// ==== mips_exe.f ====
design/cpu_pkg.sv
design/bus_pkg.sv
design/div_unit.sv
design/alu.sv
design/store_align.sv
design/exe_stage.sv
design/data_ram.sv
design/exe_top.sv
verification/exe_sva.sv
verification/exe_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exe_tb -f mips_exe.f
./obj_dir/Vexe_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== verification/exe_sva.sv ====
module exe_sva
    import cpu_pkg::*;
    import bus_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      es_valid,
    input logic      ms_allowin,
    input es_to_ms_t es_bus,
    input wb_req_t   wb_req,
    input wb_rsp_t   wb_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // strobe and cycle stay up until the slave answers
    stb_until_ack: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && wb_req.cyc)
        else $error("stb dropped before ack");

    // request fields held until the slave answers
    req_stable: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> $stable(wb_req.adr) && $stable(wb_req.we)
            && $stable(wb_req.sel) && $stable(wb_req.dat_w))
        else $error("wishbone request changed before ack");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack longer than one cycle");

    bus_held: assert property (@(posedge clk) disable iff (reset)
        es_valid && !ms_allowin |=> $stable(es_bus))
        else $error("es_bus changed under back-pressure");

endmodule

// ==== verification/exe_tb.sv ====
module exe_tb
    import cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_total = 240;   // instructions over all tests
    localparam int bus_w = $bits(es_to_ms_t);

    logic      clk = 1'b0;
    logic      reset;
    logic      ds_valid;
    ds_to_es_t ds_bus;
    logic      es_allowin;
    logic      es_valid;
    es_to_ms_t es_bus;
    logic      ms_allowin;
    es_fwd_t   es_fwd;
    logic      flush;
    logic      later_ex;

    integer    seed = 32'h8eb;
    word_t     ram_model [256];
    es_to_ms_t exp_q [$];
    logic      hi_q [$];           // compare remainder
    logic      lw_q [$];           // compare load word
    logic      ref_load_ok;
    logic      ref_bus_ok;
    word_t     pc_next = 32'hbfc0_0000;
    string     cur_test;
    int        errors = 0;
    int        checks = 0;
    int        test_errors = 0;
    int        test_count = 0;
    int        exp_acks = 0;
    int        bus_acks = 0;
    logic      rand_ready = 1'b0;
    es_to_ms_t exp_item;
    es_to_ms_t act_item;
    es_fwd_t   exp_fwd;

    bind exe_stage exe_sva sva0 (.clk(clk), .reset(reset), .es_valid(es_valid),
        .ms_allowin(ms_allowin), .es_bus(es_bus), .wb_req(wb_req), .wb_rsp(wb_rsp));

    exe_top dut0 (.clk(clk), .reset(reset), .ds_valid(ds_valid), .ds_bus(ds_bus),
        .es_allowin(es_allowin), .es_valid(es_valid), .es_bus(es_bus),
        .ms_allowin(ms_allowin), .es_fwd(es_fwd), .flush(flush), .later_ex(later_ex));

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (rand_ready) ms_allowin = ({$random(seed)} % 4) != 0;  // mostly ready
        else            ms_allowin = 1'b0;
    end

    task automatic check(input string name, input logic [bus_w-1:0] exp, act);
        checks++;
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // quotient in the upper half and remainder in the lower
    function automatic logic [63:0] div_ref(word_t a, word_t b, logic sgn);
        word_t ma;
        word_t mb;
        word_t mq;
        word_t mr;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        if (mb == 0) begin
            mq = 32'hffff_ffff;
            mr = ma;
        end else begin
            mq = ma / mb;
            mr = ma % mb;
        end
        if (sgn && (a[31] ^ b[31])) mq = -mq;
        if (sgn && a[31]) mr = -mr;
        return {mq, mr};
    endfunction

    function automatic es_to_ms_t ref_model(ds_to_es_t d, logic lex);
        es_to_ms_t  e;
        word_t      a;
        word_t      b;
        word_t      r;
        logic [32:0] s;
        logic [63:0] qr;
        logic [1:0] ofs;
        logic       ov;
        logic       ades;
        logic       adel;
        logic       ld;
        logic       st;
        a = (d.src1_sel == src1_sa) ? {27'd0, d.imm[10:6]} :
            (d.src1_sel == src1_pc) ? d.pc : d.rs_value;
        case (d.src2_sel)
            src2_imm_zero: b = {16'd0, d.imm};
            src2_imm_sign: b = {{16{d.imm[15]}}, d.imm};
            src2_eight:    b = 32'd8;
            default:       b = d.rt_value;
        endcase
        ov = 1'b0;
        qr = div_ref(a, b, d.alu_op == alu_div);
        case (d.alu_op)
            alu_add, alu_addu: begin
                s = {a[31], a} + {b[31], b};
                r = s[31:0];
                ov = (d.alu_op == alu_add) && (s[32] != s[31]);
            end
            alu_sub, alu_subu: begin
                s = {a[31], a} - {b[31], b};
                r = s[31:0];
                ov = (d.alu_op == alu_sub) && (s[32] != s[31]);
            end
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_xor:  r = a ^ b;
            alu_nor:  r = ~(a | b);
            alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_sll:  r = b << a[4:0];
            alu_srl:  r = b >> a[4:0];
            alu_sra:  r = $signed(b) >>> a[4:0];
            alu_lui:  r = {b[15:0], 16'd0};
            default:  r = qr[63:32];
        endcase
        ofs  = r[1:0];
        ld   = d.mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
        st   = d.mem_op inside {mem_sb, mem_sh, mem_sw, mem_swl, mem_swr};
        adel = (d.mem_op == mem_lw && ofs != 0) || (d.mem_op inside {mem_lh, mem_lhu} && ofs[0]);
        ades = (d.mem_op == mem_sw && ofs != 0) || (d.mem_op == mem_sh && ofs[0]);
        e = '0;
        e.pc        = d.pc;
        e.result    = r;
        e.hi_result = qr[31:0];
        e.dest      = d.dest;
        e.gr_we     = d.gr_we;
        e.mem_op    = d.mem_op;
        e.ex        = d.in_ex || ov || ades || adel;
        e.exc_code  = d.in_ex ? d.in_exc_code : ov ? exc_ov : ades ? exc_ades :
                      adel ? exc_adel : exc_none;
        ref_load_ok = ld && !e.ex && !lex;
        ref_bus_ok  = (ld || st) && !e.ex && !lex;   // one bus cycle expected
        if (ref_load_ok) e.load_word = ram_model[r[9:2]];
        if (st && !e.ex && !lex) begin
            for (int k = 0; k < 4; k++) begin
                case (d.mem_op)
                    mem_sb: if (k == ofs) ram_model[r[9:2]][8*k +: 8] = d.rt_value[7:0];
                    mem_sh: if (k - ofs inside {0, 1})
                        ram_model[r[9:2]][8*k +: 8] = d.rt_value[8*(k-ofs) +: 8];
                    mem_sw: ram_model[r[9:2]][8*k +: 8] = d.rt_value[8*k +: 8];
                    mem_swl: if (k <= ofs)
                        ram_model[r[9:2]][8*k +: 8] = d.rt_value[8*(3-ofs+k) +: 8];
                    default: if (k >= ofs)
                        ram_model[r[9:2]][8*k +: 8] = d.rt_value[8*(k-ofs) +: 8];
                endcase
            end
        end
        return e;
    endfunction

    function automatic ds_to_es_t make_inst(alu_op_e op, mem_op_e mop, src1_sel_e s1,
                                            src2_sel_e s2, word_t rs, word_t rt, logic [15:0] imm);
        ds_to_es_t d;
        d = '0;
        d.pc       = pc_next;
        pc_next    = pc_next + 4;
        d.rs_value = rs;
        d.rt_value = rt;
        d.imm      = imm;
        d.alu_op   = op;
        d.mem_op   = mop;
        d.src1_sel = s1;
        d.src2_sel = s2;
        d.dest     = 5'd1 + ({$random(seed)} % 31);
        d.gr_we    = !(mop inside {mem_sb, mem_sh, mem_sw, mem_swl, mem_swr});
        d.in_exc_code = exc_none;
        return d;
    endfunction

    task automatic send(input ds_to_es_t d, input logic expect_out);
        @(negedge clk);
        ds_valid = 1'b1;
        ds_bus   = d;
        #1;
        while (!es_allowin) begin
            @(negedge clk);
            #1;
        end
        if (expect_out) begin
            exp_q.push_back(ref_model(d, later_ex));
            hi_q.push_back(d.alu_op inside {alu_div, alu_divu});
            lw_q.push_back(ref_load_ok);
            if (ref_bus_ok) exp_acks++;
        end
        @(negedge clk);
        ds_valid = 1'b0;
    endtask

    // store through rs + imm and read the word back
    task automatic store_then_load(input mem_op_e mop, input logic [1:0] ofs);
        word_t base;
        base = {$random(seed)} & 32'h3fc;
        send(make_inst(alu_addu, mop, src1_rs, src2_imm_sign, base, $random(seed), ofs), 1'b1);
        send(make_inst(alu_addu, mem_lw, src1_rs, src2_imm_sign, base, 0, 16'd0), 1'b1);
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        check({cur_test, " bus cycles"}, exp_acks, bus_acks);
        test_count++;
        $display("test %s: done, %0d errors", cur_test, test_errors);
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        if (!reset && dut0.wb_rsp.ack) bus_acks++;
    end

    always @(posedge clk) begin
        if (!reset && es_valid && ms_allowin) begin
            if (exp_q.size() == 0) begin
                $display("stage produced an output that no instruction expected in %s", cur_test);
                errors++;
                test_errors++;
            end else begin
                exp_item = exp_q.pop_front();
                act_item = es_bus;
                if (!hi_q.pop_front()) act_item.hi_result = exp_item.hi_result;
                if (!lw_q.pop_front()) act_item.load_word = exp_item.load_word;
                check(cur_test, exp_item, act_item);
                exp_fwd.valid   = exp_item.gr_we;
                exp_fwd.dest    = exp_item.dest;
                exp_fwd.result  = exp_item.result;
                exp_fwd.is_load = exp_item.mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb,
                                                          mem_lbu};
                check({cur_test, " fwd"}, exp_fwd, es_fwd);
            end
        end
    end

    initial begin
        #((n_total * 40 * 10) + 5000);
        $display("watchdog: the tests did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        word_t ea [7];
        word_t eb [7];
        mem_op_e mop;
        ea = '{32'd7, -32'd7, 32'h8000_0000, -32'd7, 32'd7, -32'd7, 32'd0};
        eb = '{32'd0, 32'd0, 32'hffff_ffff, 32'd2, -32'd2, -32'd2, 32'd5};
        for (int i = 0; i < 256; i++) ram_model[i] = '0;
        reset = 1'b1;
        ds_valid = 1'b0;
        ds_bus = '0;
        ms_allowin = 1'b0;
        flush = 1'b0;
        later_ex = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        rand_ready = 1'b1;

        cur_test = "alu";
        for (int i = 0; i < 60; i++) begin
            if (i % 8 == 0)
                send(make_inst(alu_add, mem_none, src1_rs, src2_rt, 32'h7fff_ffff, 1, 0), 1'b1);
            else if (i % 8 == 4)
                send(make_inst(alu_sub, mem_none, src1_rs, src2_rt, 32'h8000_0000, 1, 0), 1'b1);
            else
                send(make_inst(alu_op_e'({$random(seed)} % 14), mem_none,
                    src1_sel_e'({$random(seed)} % 3), src2_sel_e'({$random(seed)} % 4),
                    $random(seed), $random(seed), $random(seed)), 1'b1);
        end
        finish_test();

        cur_test = "store";
        for (int i = 0; i < 30; i++) begin
            mop = mem_op_e'(mem_sb + (i % 5));
            store_then_load(mop, mop == mem_sw ? 2'd0 :
                mop == mem_sh ? {$random(seed)} % 2 * 2 : {$random(seed)} % 4);
        end
        finish_test();

        cur_test = "addr_err";
        for (int i = 0; i < 20; i++) begin
            mop = (i % 5 == 0) ? mem_lh : (i % 5 == 1) ? mem_lhu : (i % 5 == 2) ? mem_lw :
                  (i % 5 == 3) ? mem_sh : mem_sw;
            store_then_load(mop, mop inside {mem_lh, mem_lhu, mem_sh} ?
                2'd1 + 2 * ({$random(seed)} % 2) : 2'd1 + {$random(seed)} % 3);
        end
        ds_bus = make_inst(alu_addu, mem_sw, src1_rs, src2_imm_sign, 32'h41, 5, 0);
        ds_bus.in_ex = 1'b1;
        ds_bus.in_exc_code = exc_sys;   // keeps its code over ades
        send(ds_bus, 1'b1);
        finish_test();

        cur_test = "div";
        for (int i = 0; i < 7; i++) begin
            send(make_inst(alu_div, mem_none, src1_rs, src2_rt, ea[i], eb[i], 0), 1'b1);
            send(make_inst(alu_divu, mem_none, src1_rs, src2_rt, ea[i], eb[i], 0), 1'b1);
        end
        for (int i = 0; i < 20; i++)
            send(make_inst(i % 2 ? alu_div : alu_divu, mem_none, src1_rs, src2_rt,
                $random(seed), $random(seed) >>> (i % 24), 0), 1'b1);
        finish_test();

        cur_test = "backpressure";
        for (int i = 0; i < 40; i++) begin
            case ({$random(seed)} % 3)
                0: send(make_inst(alu_op_e'({$random(seed)} % 14), mem_none, src1_rs,
                    src2_rt, $random(seed), $random(seed), 0), 1'b1);
                1: send(make_inst(alu_addu, mem_op_e'(mem_sb + {$random(seed)} % 5), src1_rs,
                    src2_imm_sign, {$random(seed)} & 32'h3fc, $random(seed), 0), 1'b1);
                default: send(make_inst(alu_addu, mem_lw, src1_rs, src2_imm_sign,
                    {$random(seed)} & 32'h3fc, 0, 0), 1'b1);
            endcase
        end
        finish_test();

        cur_test = "later_ex_flush";
        @(negedge clk);
        later_ex = 1'b1;
        send(make_inst(alu_addu, mem_sw, src1_rs, src2_imm_sign, 32'h80, 32'h1234_5678, 0), 1'b1);
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        later_ex = 1'b0;
        send(make_inst(alu_addu, mem_lw, src1_rs, src2_imm_sign, 32'h80, 0, 0), 1'b1);
        while (exp_q.size() != 0) @(posedge clk);
        rand_ready = 1'b0;
        send(make_inst(alu_addu, mem_none, src1_rs, src2_rt, 3, 4, 0), 1'b0);
        flush = 1'b1;   // drop the item that sits in the stage
        @(negedge clk);
        flush = 1'b0;
        check({cur_test, " empty after flush"}, 2'b00, {es_valid, es_fwd.valid});
        @(posedge clk);
        rand_ready = 1'b1;
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
